/* src.f */
common/loader_pkg.sv
src/download_decode.sv
ram_loader/ram_download_port.sv
src/cheat_assembler.sv
src/loader_top.sv
sim/tb_loader.sv

/* Makefile */
TOP = tb_loader

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

/* sim/tb_loader.sv */
`default_nettype none

module tb_loader;

	localparam int RAM_CREDITS = 2;
	localparam int N_BIOS      = 16;
	localparam int N_EXE       = 24;
	localparam int N_CD        = 8;
	localparam int N_REC       = 3;
	localparam int HALFWORDS   = 2 * (N_BIOS + N_EXE + N_CD) + 8 * N_REC;
	localparam int TIMEOUT     = 200 * HALFWORDS + 2000;

	logic         clk_1x;
	logic         rst_n;
	logic         ioctl_download;
	logic [7:0]   ioctl_index;
	logic         ioctl_wr;
	logic [26:0]  ioctl_addr;
	logic [15:0]  ioctl_dout;
	logic         ioctl_wait;
	logic         mem_req;
	logic         mem_rnw;
	logic [26:0]  mem_addr;
	logic [31:0]  mem_wdata;
	logic [3:0]   mem_be;
	logic         mem_done = 1'b0;
	logic [31:0]  mem_rdata = '0;
	logic         cheat_req;
	logic         cheat_rnw;
	logic [20:0]  cheat_addr;
	logic [3:0]   cheat_be;
	logic [31:0]  cheat_wdata;
	logic         cheat_done;
	logic [31:0]  cheat_rdata;
	logic         load_exe;
	logic         trackinfo_wr;
	logic [8:0]   trackinfo_addr;
	logic [31:0]  trackinfo_data;
	logic         cheat_clear;
	logic         cheat_valid;
	logic [127:0] cheat_code;

	integer          seed;
	int              errors = 0;
	int              checks = 0;
	int              err_mark;
	int              in_flight;
	int              cycle;
	int              due;
	int              delay;
	int              load_count = 0;
	int              clear_count = 0;
	int              wait_cycles = 0;
	bit              slow = 1'b0;
	bit              cheat_phase = 1'b0;
	logic [31:0]     mem_words [64];
	logic [63:0]     exp_mem [$];
	logic [40:0]     exp_track [$];
	logic [127:0]    exp_cheat [$];
	int              due_q [$];
	logic [31:0]     data_q [$];
	logic [63:0]     mem_exp;
	logic [40:0]     track_exp;
	logic [127:0]    code_exp;
	logic [7:0][15:0] halves;
	logic [20:0]     c_addr;
	logic [3:0]      c_be;
	logic [31:0]     c_data;
	logic [31:0]     rd;
	logic [31:0]     expect_rd;

	loader_top #(.RAM_CREDITS(RAM_CREDITS)) i_dut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	// ============================================================
	// Reference rules
	// ============================================================

	function automatic logic [26:0] ref_addr(input logic [7:0] index, input logic [26:0] addr);
		case (index)
			8'd0:    return addr + 27'd2097152;
			8'd1:    return addr + 27'd4194304;
			default: return addr;
		endcase
	endfunction

	// flags, address, compare, replace; lower offset is the low half
	function automatic logic [127:0] ref_record(input logic [7:0][15:0] h);
		return {h[1], h[0], h[3], h[2], h[5], h[4], h[7], h[6]};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic report_mismatch(input string sig, input logic [127:0] got,
			input logic [127:0] exp);
		$display("error at %0t: %s = %h, expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int mark);
		if (errors == mark)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - mark);
	endtask

	// ============================================================
	// Host stream and cheat bus drivers
	// ============================================================

	// One idle cycle after each high half keeps ioctl_wait current
	task automatic send_half(input logic [26:0] addr, input logic [15:0] data);
		@(posedge clk_1x);
		while (ioctl_wait)
			@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		if (addr[1]) begin
			@(posedge clk_1x);
			ioctl_wr <= 1'b0;
		end
	endtask

	task automatic send_word(input logic [26:0] addr, input logic [15:0] lo, input logic [15:0] hi);
		if (ioctl_index == 8'd251)
			exp_track.push_back({addr[10:2], hi, lo});
		else
			exp_mem.push_back({1'b0, 4'hf, ref_addr(ioctl_index, addr), hi, lo});
		send_half(addr, lo);
		send_half(addr | 27'd2, hi);
	endtask

	task automatic open_download(input logic [7:0] index);
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		repeat (3) @(posedge clk_1x);
	endtask

	task automatic wait_drain();
		@(negedge clk_1x);
		while (exp_mem.size() != 0 || exp_track.size() != 0 || exp_cheat.size() != 0
				|| in_flight != 0)
			@(negedge clk_1x);
	endtask

	task automatic close_download();
		wait_drain();
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_1x);
	endtask

	task automatic cheat_access(input logic rnw, input logic [20:0] addr, input logic [3:0] be,
			input logic [31:0] data, output logic [31:0] rdata);
		exp_mem.push_back({rnw, be, 6'd0, addr, data});
		@(posedge clk_1x);
		cheat_req   <= 1'b1;
		cheat_rnw   <= rnw;
		cheat_addr  <= addr;
		cheat_be    <= be;
		cheat_wdata <= data;
		@(posedge clk_1x);
		cheat_req <= 1'b0;
		while (!cheat_done)
			@(posedge clk_1x);
		rdata = cheat_rdata;
	endtask

	// ============================================================
	// Memory model, in-order answers after 0 to 6 cycles
	// ============================================================

	initial begin
		for (int i = 0; i < 64; i++)
			mem_words[i] = 32'h5a3c_0000 ^ (32'(i) * 32'h0001_0307);
	end

	always @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			mem_done  <= 1'b0;
			mem_rdata <= '0;
			in_flight = 0;
			cycle     = 0;
		end else begin
			cycle = cycle + 1;
			if (mem_done)
				in_flight = in_flight - 1;
			mem_done <= 1'b0;
			if (due_q.size() != 0 && due_q[0] <= cycle) begin
				void'(due_q.pop_front());
				mem_done  <= 1'b1;
				mem_rdata <= data_q.pop_front();
			end
			if (mem_req) begin
				if (slow)
					delay = 6;
				else
					delay = $unsigned($random(seed)) % 7;
				due = cycle + 1 + delay;
				if (due_q.size() != 0 && due <= due_q[$])
					due = due_q[$] + 1;
				due_q.push_back(due);
				data_q.push_back(mem_words[mem_addr[7:2]]);
				if (!mem_rnw)
					mem_words[mem_addr[7:2]] = merge_bytes(mem_words[mem_addr[7:2]], mem_wdata, mem_be);
				in_flight = in_flight + 1;
				if (in_flight > RAM_CREDITS)
					report_failure("more RAM requests outstanding than write credits");
			end
		end
	end

	// ============================================================
	// Comparison of observed outputs
	// ============================================================

	always @(posedge clk_1x) begin
		if (rst_n) begin
			if (ioctl_wr && ioctl_wait)
				report_failure("ioctl_wr presented while ioctl_wait was high");
			if (ioctl_wait)
				wait_cycles++;
			if (load_exe)
				load_count++;
			if (cheat_clear)
				clear_count++;
			if (cheat_done && !cheat_phase)
				report_failure("cheat_done raised with no cheat access pending");
			if (mem_req && exp_mem.size() == 0)
				report_failure("mem_req with no access expected");
			if (mem_req && exp_mem.size() != 0) begin
				mem_exp = exp_mem.pop_front();
				checks++;
				if (mem_rnw !== mem_exp[63])
					report_mismatch("mem_rnw", mem_rnw, mem_exp[63]);
				if (mem_be !== mem_exp[62:59])
					report_mismatch("mem_be", mem_be, mem_exp[62:59]);
				if (mem_addr !== mem_exp[58:32])
					report_mismatch("mem_addr", mem_addr, mem_exp[58:32]);
				if (!mem_exp[63] && mem_wdata !== mem_exp[31:0])
					report_mismatch("mem_wdata", mem_wdata, mem_exp[31:0]);
			end
			if (trackinfo_wr && exp_track.size() == 0)
				report_failure("trackinfo_wr with no write expected");
			if (trackinfo_wr && exp_track.size() != 0) begin
				track_exp = exp_track.pop_front();
				checks++;
				if (trackinfo_addr !== track_exp[40:32])
					report_mismatch("trackinfo_addr", trackinfo_addr, track_exp[40:32]);
				if (trackinfo_data !== track_exp[31:0])
					report_mismatch("trackinfo_data", trackinfo_data, track_exp[31:0]);
			end
			if (cheat_valid && exp_cheat.size() == 0)
				report_failure("cheat_valid with no record expected");
			if (cheat_valid && exp_cheat.size() != 0) begin
				code_exp = exp_cheat.pop_front();
				checks++;
				if (cheat_code !== code_exp)
					report_mismatch("cheat_code", cheat_code, code_exp);
			end
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin
		seed           = 40380;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cheat_req      = 1'b0;
		cheat_rnw      = 1'b0;
		cheat_addr     = '0;
		cheat_be       = '0;
		cheat_wdata    = '0;
		repeat (3) @(posedge clk_1x);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_1x);

		err_mark = errors;
		open_download(8'd0);
		for (int w = 0; w < N_BIOS; w++)
			send_word(27'(w * 4), 16'($random(seed)), 16'($random(seed)));
		close_download();
		if (load_count != 0)
			report_failure("load_exe pulsed after a BIOS download");
		finish_test("test 1 bios download", err_mark);

		// Slow answers drain the credits
		err_mark    = errors;
		slow        = 1'b1;
		wait_cycles = 0;
		open_download(8'd1);
		for (int w = 0; w < N_EXE; w++)
			send_word(27'(w * 4), 16'($random(seed)), 16'($random(seed)));
		close_download();
		slow = 1'b0;
		if (wait_cycles == 0)
			report_failure("ioctl_wait never rose under slow mem_done");
		if (load_count != 1)
			report_failure("load_exe did not pulse exactly once after the executable");
		finish_test("test 2 executable download", err_mark);

		err_mark = errors;
		open_download(8'd251);
		for (int w = 0; w < N_CD; w++)
			send_word(27'h1000 + 27'(w * 4), 16'($random(seed)), 16'($random(seed)));
		close_download();
		finish_test("test 3 cd info download", err_mark);

		err_mark    = errors;
		clear_count = 0;
		open_download(8'd255);
		for (int r = 0; r < N_REC; r++) begin
			for (int i = 0; i < 8; i++)
				halves[i] = 16'($random(seed));
			exp_cheat.push_back(ref_record(halves));
			for (int i = 0; i < 8; i++)
				send_half(27'(r * 16 + i * 2), halves[i]);
		end
		close_download();
		if (clear_count != 1)
			report_failure("cheat_clear did not pulse exactly once");
		finish_test("test 4 code download", err_mark);

		// Read, partial write, read back
		err_mark    = errors;
		cheat_phase = 1'b1;
		for (int n = 0; n < 3; n++) begin
			c_addr    = 21'($random(seed));
			c_be      = 4'($random(seed));
			c_data    = $random(seed);
			expect_rd = mem_words[c_addr[7:2]];
			cheat_access(1'b1, c_addr, 4'hf, 32'd0, rd);
			checks++;
			if (rd !== expect_rd)
				report_mismatch("cheat_rdata", rd, expect_rd);
			cheat_access(1'b0, c_addr, c_be, c_data, rd);
			expect_rd = merge_bytes(expect_rd, c_data, c_be);
			cheat_access(1'b1, c_addr, 4'hf, 32'd0, rd);
			checks++;
			if (rd !== expect_rd)
				report_mismatch("cheat_rdata", rd, expect_rd);
		end
		wait_drain();
		cheat_phase = 1'b0;
		finish_test("test 5 cheat pass-through", err_mark);

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		repeat (TIMEOUT) @(posedge clk_1x);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src/loader_top.sv */
`default_nettype none

module loader_top #(
	parameter int RAM_CREDITS = 2
) (
	input  wire                                 clk_1x,
	input  wire                                 rst_n,
	// Host download stream
	input  wire                                 ioctl_download,
	input  wire [7:0]                           ioctl_index,
	input  wire                                 ioctl_wr,
	input  wire [loader_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  wire [loader_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	output logic                                ioctl_wait,
	// Shared RAM port
	output logic                                mem_req,
	output logic                                mem_rnw,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0] mem_addr,
	output logic [loader_pkg::MEM_DATA_W-1:0]   mem_wdata,
	output logic [loader_pkg::MEM_DATA_W/8-1:0] mem_be,
	input  wire                                 mem_done,
	input  wire [loader_pkg::MEM_DATA_W-1:0]    mem_rdata,
	// Cheat bus
	input  wire                                 cheat_req,
	input  wire                                 cheat_rnw,
	input  wire [loader_pkg::CHEAT_ADDR_W-1:0]  cheat_addr,
	input  wire [loader_pkg::MEM_DATA_W/8-1:0]  cheat_be,
	input  wire [loader_pkg::MEM_DATA_W-1:0]    cheat_wdata,
	output logic                                cheat_done,
	output logic [loader_pkg::MEM_DATA_W-1:0]   cheat_rdata,
	// To the system
	output logic                                load_exe,
	output logic                                trackinfo_wr,
	output logic [loader_pkg::TRACK_ADDR_W-1:0] trackinfo_addr,
	output logic [loader_pkg::MEM_DATA_W-1:0]   trackinfo_data,
	output logic                                cheat_clear,
	output logic                                cheat_valid,
	output logic [loader_pkg::CODE_W-1:0]       cheat_code
);

	import loader_pkg::*;

	dl_kind_t kind;

	download_decode u_download_decode (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.kind           (kind),
		.load_exe       (load_exe)
	);

	ram_download_port #(
		.RAM_CREDITS (RAM_CREDITS)
	) u_ram_download_port (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.kind           (kind),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.mem_req        (mem_req),
		.mem_rnw        (mem_rnw),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_be         (mem_be),
		.mem_done       (mem_done),
		.mem_rdata      (mem_rdata),
		.cheat_req      (cheat_req),
		.cheat_rnw      (cheat_rnw),
		.cheat_addr     (cheat_addr),
		.cheat_be       (cheat_be),
		.cheat_wdata    (cheat_wdata),
		.cheat_done     (cheat_done),
		.cheat_rdata    (cheat_rdata),
		.trackinfo_wr   (trackinfo_wr),
		.trackinfo_addr (trackinfo_addr),
		.trackinfo_data (trackinfo_data)
	);

	cheat_assembler u_cheat_assembler (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.kind        (kind),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.cheat_clear (cheat_clear),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code)
	);

endmodule

`default_nettype wire

/* src/cheat_assembler.sv */
`default_nettype none

module cheat_assembler (
	input  wire                                clk_1x,
	input  wire                                rst_n,
	input  wire loader_pkg::dl_kind_t          kind,
	input  wire                                ioctl_wr,
	input  wire [loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  wire [loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	output logic                               cheat_clear,
	output logic                               cheat_valid,
	output logic [loader_pkg::CODE_W-1:0]      cheat_code
);

	import loader_pkg::*;

	logic       code_sel;
	logic       code_sel_q;
	logic [3:0] offset;

	assign code_sel = (kind == DL_CODE);
	assign offset   = ioctl_addr[3:0];

	// Start of a code download clears the system's cheat table
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			code_sel_q  <= 1'b0;
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			code_sel_q  <= code_sel;
			cheat_clear <= code_sel && !code_sel_q;
			// Last halfword of a record
			cheat_valid <= code_sel && ioctl_wr && (offset == 4'd14);
		end
	end

	// ============================================================
	// Record fields
	// ============================================================

	// flags | address | compare | replace, low half first
	always_ff @(posedge clk_1x) begin
		if (code_sel && ioctl_wr) begin
			case (offset)
				4'd0:    cheat_code[111:96]  <= ioctl_dout;
				4'd2:    cheat_code[127:112] <= ioctl_dout;
				4'd4:    cheat_code[79:64]   <= ioctl_dout;
				4'd6:    cheat_code[95:80]   <= ioctl_dout;
				4'd8:    cheat_code[47:32]   <= ioctl_dout;
				4'd10:   cheat_code[63:48]   <= ioctl_dout;
				4'd12:   cheat_code[15:0]    <= ioctl_dout;
				4'd14:   cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* ram_loader/ram_download_port.sv */
`default_nettype none

module ram_download_port #(
	parameter int RAM_CREDITS = 2
) (
	input  wire                                     clk_1x,
	input  wire                                     rst_n,
	input  wire loader_pkg::dl_kind_t               kind,
	// Host stream
	input  wire                                     ioctl_wr,
	input  wire [loader_pkg::IOCTL_ADDR_W-1:0]      ioctl_addr,
	input  wire [loader_pkg::IOCTL_DATA_W-1:0]      ioctl_dout,
	output logic                                    ioctl_wait,
	// Shared RAM port
	output logic                                    mem_req,
	output logic                                    mem_rnw,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0]     mem_addr,
	output logic [loader_pkg::MEM_DATA_W-1:0]       mem_wdata,
	output logic [loader_pkg::MEM_DATA_W/8-1:0]     mem_be,
	input  wire                                     mem_done,
	input  wire [loader_pkg::MEM_DATA_W-1:0]        mem_rdata,
	// Cheat bus from the system
	input  wire                                     cheat_req,
	input  wire                                     cheat_rnw,
	input  wire [loader_pkg::CHEAT_ADDR_W-1:0]      cheat_addr,
	input  wire [loader_pkg::MEM_DATA_W/8-1:0]      cheat_be,
	input  wire [loader_pkg::MEM_DATA_W-1:0]        cheat_wdata,
	output logic                                    cheat_done,
	output logic [loader_pkg::MEM_DATA_W-1:0]       cheat_rdata,
	// CD track info
	output logic                                    trackinfo_wr,
	output logic [loader_pkg::TRACK_ADDR_W-1:0]     trackinfo_addr,
	output logic [loader_pkg::MEM_DATA_W-1:0]       trackinfo_data
);

	import loader_pkg::*;

	localparam int CREDIT_W = $clog2(RAM_CREDITS + 1);
	localparam int BE_W     = MEM_DATA_W / 8;

	logic                    ram_sel;
	logic                    pack_sel;
	logic                    hi_wr;
	logic                    take_credit;
	logic                    give_credit;
	logic [CREDIT_W-1:0]     credits;
	logic [IOCTL_ADDR_W-1:0] wr_addr;
	logic [IOCTL_DATA_W-1:0] wr_lo;
	logic [IOCTL_DATA_W-1:0] wr_hi;
	logic                    ram_wr_q;
	logic                    track_wr_q;

	// BIOS and executable downloads own the RAM port
	assign ram_sel  = (kind == DL_BIOS) || (kind == DL_EXE);
	assign pack_sel = ram_sel || (kind == DL_CDINFO);
	assign hi_wr    = ioctl_wr && ioctl_addr[1];

	// ============================================================
	// Halfword packing
	// ============================================================

	always_ff @(posedge clk_1x) begin
		if (pack_sel && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				wr_lo <= ioctl_dout;
				case (kind)
					DL_BIOS: wr_addr <= ioctl_addr + BIOS_BASE;
					DL_EXE:  wr_addr <= ioctl_addr + EXE_BASE;
					default: wr_addr <= ioctl_addr;
				endcase
			end else begin
				wr_hi <= ioctl_dout;
			end
		end
	end

	// Write strobes, one cycle after the high half
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			ram_wr_q   <= 1'b0;
			track_wr_q <= 1'b0;
		end else begin
			ram_wr_q   <= ram_sel && hi_wr;
			track_wr_q <= (kind == DL_CDINFO) && hi_wr;
		end
	end

	// ============================================================
	// Write credits
	// ============================================================

	assign take_credit = ram_sel && hi_wr;
	assign give_credit = ram_sel && mem_done;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(RAM_CREDITS);
		end else if (!ram_sel) begin
			// Full pool again between downloads
			credits <= CREDIT_W'(RAM_CREDITS);
		end else if (take_credit && !give_credit) begin
			credits <= credits - 1'b1;
		end else if (give_credit && !take_credit) begin
			credits <= credits + 1'b1;
		end
	end

	assign ioctl_wait = ram_sel && (credits == '0);

	// ============================================================
	// RAM port arbitration
	// ============================================================

	always_comb begin
		if (ram_sel) begin
			mem_req   = ram_wr_q;
			mem_rnw   = 1'b0;
			mem_addr  = wr_addr;
			mem_wdata = {wr_hi, wr_lo};
			mem_be    = {BE_W{1'b1}};
		end else begin
			mem_req   = cheat_req;
			mem_rnw   = cheat_rnw;
			mem_addr  = {{(IOCTL_ADDR_W - CHEAT_ADDR_W){1'b0}}, cheat_addr};
			mem_wdata = cheat_wdata;
			mem_be    = cheat_be;
		end
	end

	assign cheat_done  = !ram_sel && mem_done;
	assign cheat_rdata = mem_rdata;

	// Track info goes to the system, not the RAM
	assign trackinfo_wr   = track_wr_q;
	assign trackinfo_addr = wr_addr[TRACK_ADDR_W+1:2];
	assign trackinfo_data = {wr_hi, wr_lo};

endmodule

`default_nettype wire

/* src/download_decode.sv */
`default_nettype none

module download_decode (
	input  wire                  clk_1x,
	input  wire                  rst_n,
	input  wire                  ioctl_download,
	input  wire [7:0]            ioctl_index,
	output loader_pkg::dl_kind_t kind,
	output logic                 load_exe
);

	import loader_pkg::*;

	dl_kind_t kind_next;
	dl_kind_t kind_prev;

	// Index match, only while the host holds the download open
	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			case (ioctl_index)
				IDX_BIOS:   kind_next = DL_BIOS;
				IDX_EXE:    kind_next = DL_EXE;
				IDX_CDINFO: kind_next = DL_CDINFO;
				IDX_CODE:   kind_next = DL_CODE;
				default:    kind_next = DL_NONE;
			endcase
		end
	end

	// ============================================================
	// Kind register and end-of-executable pulse
	// ============================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			kind      <= DL_NONE;
			kind_prev <= DL_NONE;
			load_exe  <= 1'b0;
		end else begin
			kind      <= kind_next;
			kind_prev <= kind;
			// Falling edge of the executable kind
			load_exe  <= (kind_prev == DL_EXE) && (kind != DL_EXE);
		end
	end

endmodule

`default_nettype wire

/* common/loader_pkg.sv */
`default_nettype none

package loader_pkg;

	// ============================================================
	// Download kinds
	// ============================================================

	// Active download, decoded from the host index
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CDINFO,
		DL_CODE
	} dl_kind_t;

	// Host index values
	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	// ============================================================
	// Memory map and widths
	// ============================================================

	// Byte base addresses in the shared RAM
	localparam logic [26:0] BIOS_BASE = 27'd2097152;
	localparam logic [26:0] EXE_BASE  = 27'd4194304;

	// Host download stream
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;

	// Shared RAM port
	localparam int MEM_DATA_W = 32;

	// System side
	localparam int CHEAT_ADDR_W = 21;
	localparam int CODE_W       = 128;
	localparam int TRACK_ADDR_W = 9;

endpackage

`default_nettype wire
